// File: Bender.yml
package:
  name: core_cp15

sources:
  - source/mmu_pkg.sv
  - source/cp15_pkg.sv
  - source/cp15_access_if.sv
  - source/core_cp15_decode.sv
  - source/core_cp15_sysregs.sv
  - source/core_cp15_fault.sv
  - source/core_cp15_maint.sv
  - source/core_cp15_readback.sv
  - source/core_cp15.sv
  - target: test
    files:
      - verif/cp15_clock_gen.sv
      - verif/core_cp15_tb.sv

// File: filelist.f
source/mmu_pkg.sv
source/cp15_pkg.sv
source/cp15_access_if.sv
source/core_cp15_decode.sv
source/core_cp15_sysregs.sv
source/core_cp15_fault.sv
source/core_cp15_maint.sv
source/core_cp15_readback.sv
source/core_cp15.sv
verif/cp15_clock_gen.sv
verif/core_cp15_tb.sv

// File: source/core_cp15.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15
	import mmu_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          transfer,
	input  logic          halt,
	input  logic          fault_register,
	input  logic          fault_page,
	input  word           instr,
	input  word           write,
	input  ptr            fault_addr,
	input  mmu_fault_type fault_type,
	input  mmu_domain     fault_domain,

	output word           read,
	output logic          undef,
	output logic          mmu_enable,
	output logic          high_vectors,
	output mmu_base       mmu_ttbr,
	output word           mmu_dac,

	output logic          cache_op,
	output logic          tlb_op,
	output logic          maint_all,
	output logic          maint_setway,
	output logic [19:0]   maint_page,
	output logic [6:0]    maint_set,
	output logic [1:0]    maint_way
);

	word read_syscfg, read_ttbr, read_dac, read_fsr, read_far;

	cp15_access_if acc ();

	core_cp15_decode u_decode (
		.transfer (transfer),
		.instr    (instr),
		.write    (write),
		.undef    (undef),
		.acc      (acc.dec)
	);

	core_cp15_sysregs u_sysregs (
		.clk          (clk),
		.rst          (rst),
		.acc          (acc.exec),
		.mmu_enable   (mmu_enable),
		.high_vectors (high_vectors),
		.mmu_ttbr     (mmu_ttbr),
		.mmu_dac      (mmu_dac),
		.read_syscfg  (read_syscfg),
		.read_ttbr    (read_ttbr),
		.read_dac     (read_dac)
	);

	core_cp15_fault u_fault (
		.clk            (clk),
		.rst            (rst),
		.halt           (halt),
		.fault_register (fault_register),
		.fault_page     (fault_page),
		.fault_addr     (fault_addr),
		.fault_type     (fault_type),
		.fault_domain   (fault_domain),
		.acc            (acc.exec),
		.read_fsr       (read_fsr),
		.read_far       (read_far)
	);

	core_cp15_maint u_maint (
		.clk          (clk),
		.rst          (rst),
		.acc          (acc.exec),
		.cache_op     (cache_op),
		.tlb_op       (tlb_op),
		.maint_all    (maint_all),
		.maint_setway (maint_setway),
		.maint_page   (maint_page),
		.maint_set    (maint_set),
		.maint_way    (maint_way)
	);

	core_cp15_readback u_readback (
		.clk         (clk),
		.rst         (rst),
		.halt        (halt),
		.acc         (acc.rd),
		.acc_w       (acc.exec),
		.read_syscfg (read_syscfg),
		.read_ttbr   (read_ttbr),
		.read_dac    (read_dac),
		.read_fsr    (read_fsr),
		.read_far    (read_far),
		.read        (read)
	);

endmodule

`default_nettype wire

// File: source/core_cp15_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_decode
	import mmu_pkg::*;
	import cp15_pkg::*;
(
	input  logic          transfer,
	input  word           instr,
	input  word           write,
	output logic          undef,
	cp15_access_if.dec    acc
);

	logic   load;
	cp_num  cpnum;
	reg_num crn;
	logic   store;

	assign load  = instr[CP15_L_BIT];
	assign cpnum = instr[CP15_CPNUM_HI:CP15_CPNUM_LO];
	assign crn   = instr[CP15_CRN_HI:CP15_CRN_LO];

	assign acc.crn   = crn;
	assign acc.crm   = instr[CP15_CRM_HI:CP15_CRM_LO];
	assign acc.op2   = instr[CP15_OP2_HI:CP15_OP2_LO];
	assign acc.wdata = write;

	assign store = transfer && !load; // Only MCR changes state.

	always_comb begin
		acc.we_syscfg   = 1'b0;
		acc.we_ttbr     = 1'b0;
		acc.we_dac      = 1'b0;
		acc.we_fsr      = 1'b0;
		acc.we_far      = 1'b0;
		acc.we_cyclecnt = 1'b0;
		acc.mnt_cache   = 1'b0;
		acc.mnt_tlb     = 1'b0;
		undef           = 1'b0;

		if (transfer && cpnum != CP15_CPNUM)
			undef = 1'b1;
		else if (transfer) begin
			case (crn)
				CP15_CRN_CPUID:    ; // Read only, a store is dropped.
				CP15_CRN_SYSCFG:   acc.we_syscfg   = store;
				CP15_CRN_TTBR:     acc.we_ttbr     = store;
				CP15_CRN_DOMAIN:   acc.we_dac      = store;
				CP15_CRN_FSR:      acc.we_fsr      = store;
				CP15_CRN_FAR:      acc.we_far      = store;
				CP15_CRN_CACHE:    acc.mnt_cache   = store;
				CP15_CRN_TLB:      acc.mnt_tlb     = store;
				CP15_CRN_CYCLECNT: acc.we_cyclecnt = store;
				default:           undef = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/core_cp15_fault.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_fault
	import mmu_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          halt,
	input  logic          fault_register,
	input  logic          fault_page,
	input  ptr            fault_addr,
	input  mmu_fault_type fault_type,
	input  mmu_domain     fault_domain,
	cp15_access_if.exec   acc,

	output word           read_fsr,
	output word           read_far
);

	word           wdata;
	logic          capture;
	mmu_domain     fsr_domain;
	mmu_fault_type fsr_status;
	ptr            far;

	assign wdata   = acc.wdata;
	assign capture = fault_register && !halt;

	always_ff @(posedge clk) begin
		if (rst) begin
			fsr_domain <= '0;
			fsr_status <= '0;
			far        <= '0;
		end else begin
			// Hardware capture takes priority over an MCR in the same cycle.
			if (capture) begin
				fsr_domain <= fault_domain;
				fsr_status <= fault_type;
			end else if (acc.we_fsr) begin
				fsr_domain <= wdata[7:4];
				fsr_status <= wdata[3:0];
			end

			if (capture && fault_page)
				far <= fault_addr;
			else if (acc.we_far)
				far <= wdata;
		end
	end

	assign read_fsr = {24'b0, fsr_domain, fsr_status};
	assign read_far = far;

endmodule

`default_nettype wire

// File: source/core_cp15_maint.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_maint
	import cp15_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	cp15_access_if.exec acc,

	output logic        cache_op,
	output logic        tlb_op,
	output logic        maint_all,
	output logic        maint_setway,
	output logic [19:0] maint_page,
	output logic [6:0]  maint_set,
	output logic [1:0]  maint_way
);

	logic is_all, is_va, is_setway;
	logic cache_hit, tlb_hit;

	assign is_all    = acc.crm == CP15_MNT_CRM_ALL    && acc.op2 == CP15_MNT_OP2_ALL;
	assign is_va     = acc.crm == CP15_MNT_CRM_VA     && acc.op2 == CP15_MNT_OP2_VA;
	assign is_setway = acc.crm == CP15_MNT_CRM_SETWAY && acc.op2 == CP15_MNT_OP2_SETWAY;

	// Set/way operations have no TLB counterpart.
	assign cache_hit = acc.mnt_cache && (is_all || is_va || is_setway);
	assign tlb_hit   = acc.mnt_tlb && (is_all || is_va);

	always_ff @(posedge clk) begin
		if (rst) begin
			cache_op     <= 1'b0;
			tlb_op       <= 1'b0;
			maint_all    <= 1'b0;
			maint_setway <= 1'b0;
			maint_page   <= '0;
			maint_set    <= '0;
			maint_way    <= '0;
		end else begin
			cache_op <= cache_hit;
			tlb_op   <= tlb_hit;

			// Operands stay put between operations.
			if (cache_hit || tlb_hit) begin
				maint_all    <= is_all;
				maint_setway <= is_setway;
				maint_page   <= acc.wdata.addr.page;
				maint_set    <= acc.wdata.setway.set;
				maint_way    <= acc.wdata.setway.way;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/core_cp15_readback.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_readback
	import mmu_pkg::*;
	import cp15_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        halt,
	cp15_access_if.rd   acc,
	cp15_access_if.exec acc_w,

	input  word         read_syscfg,
	input  word         read_ttbr,
	input  word         read_dac,
	input  word         read_fsr,
	input  word         read_far,

	output word         read
);

	word cyclecnt;

	always_ff @(posedge clk) begin
		if (rst)
			cyclecnt <= '0;
		else if (acc_w.we_cyclecnt)
			cyclecnt <= acc_w.wdata; // A write replaces this cycle's increment.
		else if (!halt)
			cyclecnt <= cyclecnt + 32'd1;
	end

	always_comb begin
		case (acc.crn)
			CP15_CRN_CPUID:    read = CP15_CPUID_VALUE;
			CP15_CRN_SYSCFG:   read = read_syscfg;
			CP15_CRN_TTBR:     read = read_ttbr;
			CP15_CRN_DOMAIN:   read = read_dac;
			CP15_CRN_FSR:      read = read_fsr;
			CP15_CRN_FAR:      read = read_far;
			CP15_CRN_CYCLECNT: read = cyclecnt;
			default:           read = '0; // Maintenance and unmapped registers.
		endcase
	end

endmodule

`default_nettype wire

// File: source/core_cp15_sysregs.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_sysregs
	import mmu_pkg::*;
	import cp15_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	cp15_access_if.exec acc,

	output logic       mmu_enable,
	output logic       high_vectors,
	output mmu_base    mmu_ttbr,
	output word        mmu_dac,

	output word        read_syscfg,
	output word        read_ttbr,
	output word        read_dac
);

	word     wdata;
	logic    syscfg_m, syscfg_v;
	mmu_base ttbr;
	word     dac;

	assign wdata = acc.wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			syscfg_m <= 1'b0;
			syscfg_v <= 1'b0;
			ttbr     <= '0;
			dac      <= '0;
		end else begin
			if (acc.we_syscfg) begin
				syscfg_m <= wdata[SYSCFG_M_BIT];
				syscfg_v <= wdata[SYSCFG_V_BIT];
			end

			if (acc.we_ttbr)
				ttbr <= wdata[31:14];

			if (acc.we_dac)
				dac <= wdata;
		end
	end

	assign mmu_enable   = syscfg_m;
	assign high_vectors = syscfg_v;
	assign mmu_ttbr     = ttbr;
	assign mmu_dac      = dac;

	// All other configuration bits are unimplemented and read as zero.
	always_comb begin
		read_syscfg               = '0;
		read_syscfg[SYSCFG_M_BIT] = syscfg_m;
		read_syscfg[SYSCFG_V_BIT] = syscfg_v;
	end

	assign read_ttbr = {ttbr, 14'b0}; // Table is 16 KiB aligned.
	assign read_dac  = dac;

endmodule

`default_nettype wire

// File: source/cp15_access_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cp15_access_if import cp15_pkg::*; ();

	reg_num    crn;
	reg_num    crm;
	cp_opcode  op2;
	maint_word wdata;

	logic we_syscfg, we_ttbr, we_dac, we_fsr, we_far, we_cyclecnt;
	logic mnt_cache, mnt_tlb;

	modport dec (
		output crn, crm, op2, wdata,
		output we_syscfg, we_ttbr, we_dac, we_fsr, we_far, we_cyclecnt,
		output mnt_cache, mnt_tlb
	);

	modport exec (
		input crm, op2, wdata,
		input we_syscfg, we_ttbr, we_dac, we_fsr, we_far, we_cyclecnt,
		input mnt_cache, mnt_tlb
	);

	modport rd (input crn);

endinterface

`default_nettype wire

// File: source/cp15_pkg.sv
`default_nettype none

package cp15_pkg;

	typedef logic [3:0] reg_num;
	typedef logic [2:0] cp_opcode;
	typedef logic [3:0] cp_num;

	localparam cp_num CP15_CPNUM = 4'd15;

	localparam reg_num CP15_CRN_CPUID    = 4'd0;
	localparam reg_num CP15_CRN_SYSCFG   = 4'd1;
	localparam reg_num CP15_CRN_TTBR     = 4'd2;
	localparam reg_num CP15_CRN_DOMAIN   = 4'd3;
	localparam reg_num CP15_CRN_FSR      = 4'd5;
	localparam reg_num CP15_CRN_FAR      = 4'd6;
	localparam reg_num CP15_CRN_CACHE    = 4'd7;
	localparam reg_num CP15_CRN_TLB      = 4'd8;
	localparam reg_num CP15_CRN_CYCLECNT = 4'd15;

	localparam logic [31:0] CP15_CPUID_VALUE = 32'h4107_2150;

	localparam int SYSCFG_M_BIT = 0;  // MMU enable.
	localparam int SYSCFG_V_BIT = 13; // High exception vectors.

	// Field layout of an MCR/MRC instruction word.
	localparam int CP15_OP1_HI   = 23;
	localparam int CP15_OP1_LO   = 21;
	localparam int CP15_L_BIT    = 20;
	localparam int CP15_CRN_HI   = 19;
	localparam int CP15_CRN_LO   = 16;
	localparam int CP15_RD_HI    = 15;
	localparam int CP15_RD_LO    = 12;
	localparam int CP15_CPNUM_HI = 11;
	localparam int CP15_CPNUM_LO = 8;
	localparam int CP15_OP2_HI   = 7;
	localparam int CP15_OP2_LO   = 5;
	localparam int CP15_CRM_HI   = 3;
	localparam int CP15_CRM_LO   = 0;

	// Invalidate all and invalidate by address exist for both CRn 7 and CRn 8.
	localparam reg_num   CP15_MNT_CRM_ALL    = 4'd7;
	localparam cp_opcode CP15_MNT_OP2_ALL    = 3'd0;
	localparam reg_num   CP15_MNT_CRM_VA     = 4'd7;
	localparam cp_opcode CP15_MNT_OP2_VA     = 3'd1;
	localparam reg_num   CP15_MNT_CRM_SETWAY = 4'd10; // Cache only.
	localparam cp_opcode CP15_MNT_OP2_SETWAY = 3'd2;

	typedef struct packed {
		logic [19:0] page;
		logic [11:0] offset;
	} maint_addr_view;

	typedef struct packed {
		logic [1:0]  way;
		logic [17:0] zero;
		logic [6:0]  set;
		logic [4:0]  low;
	} maint_setway_view;

	typedef union packed {
		maint_addr_view   addr;
		maint_setway_view setway;
	} maint_word;

endpackage

`default_nettype wire

// File: source/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	typedef logic [31:0] word;
	typedef logic [31:0] ptr;

	typedef logic [3:0] mmu_domain;
	typedef logic [3:0] mmu_fault_type;

	// Translation table base, address bits 31 to 14.
	typedef logic [17:0] mmu_base;

	// Status codes reported by the MMU on a translation or access fault.
	localparam mmu_fault_type MMU_FAULT_TRANSLATION_SECTION = 4'b0101;
	localparam mmu_fault_type MMU_FAULT_TRANSLATION_PAGE    = 4'b0111;
	localparam mmu_fault_type MMU_FAULT_DOMAIN_SECTION      = 4'b1001;
	localparam mmu_fault_type MMU_FAULT_DOMAIN_PAGE         = 4'b1011;
	localparam mmu_fault_type MMU_FAULT_PERMISSION_SECTION  = 4'b1101;
	localparam mmu_fault_type MMU_FAULT_PERMISSION_PAGE     = 4'b1111;

endpackage

`default_nettype wire

// File: verif/core_cp15_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_cp15_tb
	import mmu_pkg::*;
	import cp15_pkg::*;
();

	// Row control flags.
	localparam logic [7:0] ROW_RND   = 8'h80;
	localparam logic [7:0] ROW_HALT  = 8'h40;
	localparam logic [7:0] ROW_FREG  = 8'h20;
	localparam logic [7:0] ROW_FPAGE = 8'h10;
	localparam logic [7:0] ROW_UNDEF = 8'h08;
	localparam logic [7:0] ROW_CACHE = 8'h04;
	localparam logic [7:0] ROW_TLB   = 8'h02;
	localparam logic [7:0] ROW_FIXED = 8'h01; // Compare read with the row value.

	typedef struct {
		word        instr;
		word        wdata;
		logic [7:0] ctl;
		ptr         faddr;
		logic [7:0] fault; // Domain in the high nibble, status in the low one.
		word        exp_read;
	} row_t;

	logic clk, rst;
	logic transfer, halt, fault_register, fault_page;
	word  instr, write, read;
	ptr   fault_addr;
	mmu_fault_type fault_type;
	mmu_domain     fault_domain;
	logic undef, mmu_enable, high_vectors, cache_op, tlb_op, maint_all, maint_setway;
	mmu_base mmu_ttbr;
	word     mmu_dac;
	logic [19:0] maint_page;
	logic [6:0]  maint_set;
	logic [1:0]  maint_way;

	row_t rows[$];
	word  rng = 32'heb01_c781;
	int   error_count;
	int   cycle_count;
	int   timeout_limit = 1000;
	logic maint_hit;

	// Reference model state.
	logic m_cfg_m, m_cfg_v, m_all, m_sw;
	mmu_base m_ttbr;
	word m_dac, m_far, m_cnt;
	logic [7:0] m_fsr;
	logic [19:0] m_page;
	logic [6:0] m_set;
	logic [1:0] m_way;

	cp15_clock_gen u_clock (.clk(clk), .rst(rst));

	core_cp15 u_dut (
		.clk(clk), .rst(rst), .transfer(transfer), .halt(halt),
		.fault_register(fault_register), .fault_page(fault_page),
		.instr(instr), .write(write), .fault_addr(fault_addr),
		.fault_type(fault_type), .fault_domain(fault_domain),
		.read(read), .undef(undef), .mmu_enable(mmu_enable),
		.high_vectors(high_vectors), .mmu_ttbr(mmu_ttbr), .mmu_dac(mmu_dac),
		.cache_op(cache_op), .tlb_op(tlb_op), .maint_all(maint_all),
		.maint_setway(maint_setway), .maint_page(maint_page),
		.maint_set(maint_set), .maint_way(maint_way)
	);

	function automatic word xorshift(input word x);
		word y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word encode_cp(input logic load, input logic [3:0] cp,
			input logic [3:0] crn, input logic [3:0] crm, input logic [2:0] op2);
		return {4'hE, 4'hE, 3'b000, load, crn, 4'h0, cp, op2, 1'b1, crm};
	endfunction

	function automatic word mcr(input logic [3:0] crn, input logic [3:0] crm,
			input logic [2:0] op2);
		return encode_cp(1'b0, 4'd15, crn, crm, op2);
	endfunction

	function automatic word mrc(input logic [3:0] crn);
		return encode_cp(1'b1, 4'd15, crn, 4'd0, 3'd0);
	endfunction

	function automatic word model_read(input logic [3:0] crn);
		case (crn)
			CP15_CRN_CPUID:    return CP15_CPUID_VALUE;
			CP15_CRN_SYSCFG:   return {18'b0, m_cfg_v, 12'b0, m_cfg_m};
			CP15_CRN_TTBR:     return {m_ttbr, 14'b0};
			CP15_CRN_DOMAIN:   return m_dac;
			CP15_CRN_FSR:      return {24'b0, m_fsr};
			CP15_CRN_FAR:      return m_far;
			CP15_CRN_CYCLECNT: return m_cnt;
			default:           return 32'h0;
		endcase
	endfunction

	task automatic add_row(input word ins, input word data, input logic [7:0] ctl,
			input ptr faddr, input logic [7:0] fault, input word exp_read);
		row_t r;
		r.instr    = ins;
		r.wdata    = data;
		r.ctl      = ctl;
		r.faddr    = faddr;
		r.fault    = fault;
		r.exp_read = exp_read;
		rows.push_back(r);
	endtask

	task automatic fill_rows;
		// Reset values, counter held by halt.
		add_row(mrc(CP15_CRN_CPUID), 0, ROW_HALT | ROW_FIXED, 0, 0, CP15_CPUID_VALUE);
		add_row(mrc(CP15_CRN_SYSCFG), 0, ROW_HALT | ROW_FIXED, 0, 0, 0);
		add_row(mrc(CP15_CRN_TTBR), 0, ROW_HALT | ROW_FIXED, 0, 0, 0);
		add_row(mrc(CP15_CRN_DOMAIN), 0, ROW_HALT | ROW_FIXED, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, ROW_HALT | ROW_FIXED, 0, 0, 0);
		add_row(mcr(CP15_CRN_SYSCFG, 0, 0), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_TTBR, 0, 0), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_DOMAIN, 0, 0), 0, ROW_RND, 0, 0, 0);
		add_row(mrc(CP15_CRN_SYSCFG), 0, ROW_RND, 0, 0, 0);
		add_row(mrc(CP15_CRN_TTBR), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_SYSCFG, 0, 0), 32'hffff_ffff, 0, 0, 0, 0);
		add_row(mrc(CP15_CRN_SYSCFG), 0, ROW_FIXED, 0, 0, 32'h0000_2001);
		// Fault capture.
		add_row(mrc(CP15_CRN_FSR), 0, ROW_FREG | ROW_FPAGE, 32'h1234_5678,
			{4'h3, MMU_FAULT_PERMISSION_PAGE}, 0);
		add_row(mrc(CP15_CRN_FAR), 0, ROW_FREG | ROW_FIXED, 32'hdead_0000,
			{4'h5, MMU_FAULT_TRANSLATION_SECTION}, 32'h1234_5678);
		add_row(mrc(CP15_CRN_FSR), 0, ROW_HALT | ROW_FREG | ROW_FPAGE | ROW_FIXED,
			32'h0000_ffff, {4'h1, MMU_FAULT_DOMAIN_SECTION}, 32'h0000_0055);
		add_row(mcr(CP15_CRN_FSR, 0, 0), 32'h0000_00ab, ROW_FREG, 0,
			{4'h2, MMU_FAULT_DOMAIN_PAGE}, 0);
		add_row(mcr(CP15_CRN_FAR, 0, 0), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_FSR, 0, 0), 0, ROW_RND, 0, 0, 0);
		// Maintenance encodings, then combinations that must not pulse.
		add_row(mcr(CP15_CRN_CACHE, 4'd7, 3'd0), 0, ROW_RND | ROW_CACHE, 0, 0, 0);
		add_row(mcr(CP15_CRN_CACHE, 4'd7, 3'd1), 0, ROW_RND | ROW_CACHE, 0, 0, 0);
		add_row(mcr(CP15_CRN_CACHE, 4'd10, 3'd2), 0, ROW_RND | ROW_CACHE, 0, 0, 0);
		add_row(mcr(CP15_CRN_TLB, 4'd7, 3'd0), 0, ROW_RND | ROW_TLB, 0, 0, 0);
		add_row(mcr(CP15_CRN_TLB, 4'd7, 3'd1), 0, ROW_RND | ROW_TLB, 0, 0, 0);
		add_row(mcr(CP15_CRN_TLB, 4'd10, 3'd2), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_CACHE, 4'd7, 3'd3), 0, ROW_RND, 0, 0, 0);
		add_row(mcr(CP15_CRN_CACHE, 4'd5, 3'd0), 0, ROW_RND, 0, 0, 0);
		// Cycle counter load, count and hold.
		add_row(mcr(CP15_CRN_CYCLECNT, 0, 0), 0, ROW_RND, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, 0, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, 0, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, ROW_HALT, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, ROW_HALT, 0, 0, 0);
		add_row(mrc(CP15_CRN_CYCLECNT), 0, 0, 0, 0, 0);
		// Undefined accesses leave every register alone.
		add_row(encode_cp(1'b0, 4'd14, CP15_CRN_SYSCFG, 0, 0), 0, ROW_RND | ROW_UNDEF, 0, 0, 0);
		add_row(mcr(4'd4, 0, 0), 0, ROW_RND | ROW_UNDEF, 0, 0, 0);
		add_row(mrc(4'd9), 0, ROW_UNDEF | ROW_FIXED, 0, 0, 0);
		add_row(mrc(CP15_CRN_SYSCFG), 0, 0, 0, 0, 0);
		add_row(mcr(CP15_CRN_CPUID, 0, 0), 0, ROW_RND | ROW_FIXED, 0, 0, CP15_CPUID_VALUE);
	endtask

	// Applies the register rules to the inputs the DUT saw at this edge.
	task automatic update_model;
		logic [3:0] crn;
		logic [3:0] crm;
		logic       store;
		logic       capture;
		crn     = instr[19:16];
		crm     = instr[3:0];
		store   = transfer && !instr[20] && instr[11:8] == 4'd15;
		capture = fault_register && !halt;
		if (capture)
			m_fsr = {fault_domain, fault_type};
		else if (store && crn == CP15_CRN_FSR)
			m_fsr = write[7:0];
		if (capture && fault_page)
			m_far = fault_addr;
		else if (store && crn == CP15_CRN_FAR)
			m_far = write;
		if (store && crn == CP15_CRN_SYSCFG) begin
			m_cfg_m = write[0];
			m_cfg_v = write[13];
		end
		if (store && crn == CP15_CRN_TTBR)
			m_ttbr = write[31:14];
		if (store && crn == CP15_CRN_DOMAIN)
			m_dac = write;
		if (store && crn == CP15_CRN_CYCLECNT)
			m_cnt = write;
		else if (!halt)
			m_cnt = m_cnt + 32'd1;
		if (maint_hit) begin
			m_all  = crm == 4'd7 && instr[7:5] == 3'd0;
			m_sw   = crm == 4'd10;
			m_page = write[31:12];
			m_set  = write[11:5];
			m_way  = write[31:30];
		end
	endtask

	task automatic next_edge;
		@(posedge clk);
		update_model();
		#1;
	endtask

	task automatic report_mismatch(input int row, input string name, input word exp,
			input word act);
		$display("ERROR row %0d %s: expected %h, actual %h", row, name, exp, act);
		error_count++;
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("timeout after %0d cycles, the row loop did not finish", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		row_t r;
		int   errors_before;
		word  exp_read;
		logic [3:0] crn;
		transfer = 1'b0;
		halt = 1'b1;
		fault_register = 1'b0;
		fault_page = 1'b0;
		instr = '0;
		write = '0;
		fault_addr = '0;
		fault_type = '0;
		fault_domain = '0;
		maint_hit = 1'b0;
		{m_cfg_m, m_cfg_v, m_all, m_sw, m_ttbr, m_dac, m_far, m_cnt} = '0;
		{m_fsr, m_page, m_set, m_way} = '0;
		fill_rows();
		timeout_limit = rows.size() * 2 + 4 + 20;
		wait (!rst);
		foreach (rows[i]) begin
			r = rows[i];
			crn = r.instr[19:16];
			errors_before = error_count;
			next_edge();
			if (|(r.ctl & ROW_RND))
				rng = xorshift(rng);
			instr = r.instr;
			write = (|(r.ctl & ROW_RND)) ? rng : r.wdata;
			transfer = 1'b1;
			halt = |(r.ctl & ROW_HALT);
			fault_register = |(r.ctl & ROW_FREG);
			fault_page = |(r.ctl & ROW_FPAGE);
			fault_addr = r.faddr;
			{fault_domain, fault_type} = r.fault;
			maint_hit = |(r.ctl & (ROW_CACHE | ROW_TLB));
			@(negedge clk);
			exp_read = (|(r.ctl & ROW_FIXED)) ? r.exp_read : model_read(crn);
			if (undef !== |(r.ctl & ROW_UNDEF))
				report_mismatch(i, "undef", |(r.ctl & ROW_UNDEF), undef);
			if (read !== exp_read)
				report_mismatch(i, "read", exp_read, read);
			// The cycle before had no transfer, so no pulse is due here.
			if (cache_op !== 1'b0)
				report_mismatch(i, "cache_op", 0, cache_op);
			if (tlb_op !== 1'b0)
				report_mismatch(i, "tlb_op", 0, tlb_op);
			next_edge();
			transfer = 1'b0;
			fault_register = 1'b0;
			fault_page = 1'b0;
			maint_hit = 1'b0;
			@(negedge clk); // Cycle after the transfer.
			if (undef !== 1'b0)
				report_mismatch(i, "undef", 0, undef);
			if (read !== model_read(crn))
				report_mismatch(i, "read", model_read(crn), read);
			if (mmu_enable !== m_cfg_m)
				report_mismatch(i, "mmu_enable", m_cfg_m, mmu_enable);
			if (high_vectors !== m_cfg_v)
				report_mismatch(i, "high_vectors", m_cfg_v, high_vectors);
			if (mmu_ttbr !== m_ttbr)
				report_mismatch(i, "mmu_ttbr", m_ttbr, mmu_ttbr);
			if (mmu_dac !== m_dac)
				report_mismatch(i, "mmu_dac", m_dac, mmu_dac);
			if (cache_op !== |(r.ctl & ROW_CACHE))
				report_mismatch(i, "cache_op", |(r.ctl & ROW_CACHE), cache_op);
			if (tlb_op !== |(r.ctl & ROW_TLB))
				report_mismatch(i, "tlb_op", |(r.ctl & ROW_TLB), tlb_op);
			if (maint_all !== m_all)
				report_mismatch(i, "maint_all", m_all, maint_all);
			if (maint_setway !== m_sw)
				report_mismatch(i, "maint_setway", m_sw, maint_setway);
			if (maint_page !== m_page)
				report_mismatch(i, "maint_page", m_page, maint_page);
			if (maint_set !== m_set)
				report_mismatch(i, "maint_set", m_set, maint_set);
			if (maint_way !== m_way)
				report_mismatch(i, "maint_way", m_way, maint_way);
			$display("row %0d: %s", i, (error_count == errors_before) ? "ok" : "mismatch");
		end
		$display("%0d rows run, %0d errors", rows.size(), error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/cp15_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module cp15_clock_gen (
	output logic clk,
	output logic rst
);

	localparam time HALF_PERIOD = 50ns;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset spans four rising edges and drops just after the fourth.
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire
